/* all.f */
design/rv_core_pkg.sv
design/register_file.sv
design/instr_decode.sv
design/alu_execute.sv
design/result_stage.sv
design/int_core.sv
bench/result_checker.sv
bench/tb_int_core.sv

/* bench/result_checker.sv */
`timescale 1ns/1ps

module result_checker import rv_core_pkg::*; #(
  parameter int DATA_WIDTH = XLEN,
  parameter int N_REGS     = NUM_REGS
) (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_valid,
  input  logic [31:0]               i_instr,
  input  logic                      i_dut_valid,
  input  logic                      i_dut_illegal,
  input  logic [$clog2(N_REGS)-1:0] i_dut_rd,
  input  logic [DATA_WIDTH-1:0]     i_dut_result,
  output int                        o_value_errs,
  output int                        o_order_errs,
  output int                        o_pending
);

  localparam int RW = $clog2(N_REGS);
  localparam int SW = $clog2(DATA_WIDTH);

  logic [DATA_WIDTH-1:0] arch [0:31];  // Architectural registers
  int                    cyc;
  int                    exp_due [$];
  logic                  exp_ill [$];
  logic [4:0]            exp_rd [$];
  logic [DATA_WIDTH-1:0] exp_res [$];
  logic [31:0]           exp_word [$];
  logic [DATA_WIDTH-1:0] res;
  logic                  ill;
  logic [4:0]            rd;

  function automatic logic [DATA_WIDTH-1:0] ref_result(input logic [31:0] w,
                                                       output logic bad,
                                                       output logic [4:0] dst);
    logic [6:0]            opc;
    logic [6:0]            f7;
    logic [2:0]            f3;
    logic                  is_imm;
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
    logic [SW-1:0]         sh;
    logic [DATA_WIDTH-1:0] r;
    opc    = w[6:0];
    f3     = w[14:12];
    f7     = w[31:25];
    dst    = w[11:7];
    is_imm = (opc == OPC_OP_IMM);
    a      = arch[w[19:15]];
    b      = is_imm ? {{(DATA_WIDTH-12){w[31]}}, w[31:20]} : arch[w[24:20]];
    sh     = b[SW-1:0];
    bad    = 1'b0;
    if (opc == OPC_OP) begin
      bad = !((f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5))));
    end else if (is_imm) begin
      if (f3 == 3'd1) bad = (f7 != 7'h00);
      if (f3 == 3'd5) bad = (f7 != 7'h00) && (f7 != 7'h20);
    end else begin
      bad = 1'b1;  // Unsupported opcode
    end
    if ((w[11:7] >= N_REGS) || (w[19:15] >= N_REGS) || (!is_imm && (w[24:20] >= N_REGS))) begin
      bad = 1'b1;
    end
    case (f3)
      3'd0: r = (!is_imm && f7[5]) ? a - b : a + b;
      3'd1: r = a << sh;
      3'd2: r = {{(DATA_WIDTH-1){1'b0}}, $signed(a) < $signed(b)};
      3'd3: r = {{(DATA_WIDTH-1){1'b0}}, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (f7[5]) begin
          r = $signed(a) >>> sh;  // Sign fill
        end else begin
          r = a >> sh;
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    if (bad) begin
      dst = 5'd0;
      r   = '0;
    end
    return r;
  endfunction

  initial begin
    cyc          = 0;
    o_value_errs = 0;
    o_order_errs = 0;
    o_pending    = 0;
    for (int k = 0; k < 32; k++) arch[k] = '0;
  end

  // Model each accepted instruction in program order
  always @(posedge i_clk) begin
    cyc = cyc + 1;
    if (i_rst) begin
      for (int k = 0; k < 32; k++) arch[k] = '0;
    end else if (i_valid) begin
      res = ref_result(i_instr, ill, rd);
      if (!ill && (rd != 5'd0)) arch[rd] = res;
      exp_due.push_back(cyc + 1);  // Visible after the next edge
      exp_ill.push_back(ill);
      exp_rd.push_back(rd);
      exp_res.push_back(res);
      exp_word.push_back(i_instr);
    end
    o_pending = exp_due.size();
  end

  always @(negedge i_clk) begin
    if (cyc > 0) begin
      if (i_rst) begin
        if ((i_dut_valid !== 1'b0) || (i_dut_illegal !== 1'b0)) begin
          o_order_errs++;
          $display("o_valid or o_illegal is not low during reset at cycle %0d", cyc);
        end
      end else if ((exp_due.size() > 0) && (exp_due[0] == cyc)) begin
        if (i_dut_valid !== 1'b1) begin
          o_order_errs++;
          $display("Missing o_valid for instruction %h at cycle %0d", exp_word[0], cyc);
        end else begin
          if (i_dut_illegal !== exp_ill[0]) begin
            o_value_errs++;
            $display("Error: o_illegal expected %h got %h (instr %h)",
                     exp_ill[0], i_dut_illegal, exp_word[0]);
          end
          if (i_dut_rd !== RW'(exp_rd[0])) begin
            o_value_errs++;
            $display("Error: o_rd expected %h got %h (instr %h)",
                     exp_rd[0], i_dut_rd, exp_word[0]);
          end
          if (i_dut_result !== exp_res[0]) begin
            o_value_errs++;
            $display("Error: o_result expected %h got %h (instr %h)",
                     exp_res[0], i_dut_result, exp_word[0]);
          end
        end
        void'(exp_due.pop_front());
        void'(exp_ill.pop_front());
        void'(exp_rd.pop_front());
        void'(exp_res.pop_front());
        void'(exp_word.pop_front());
      end else if (i_dut_valid !== 1'b0) begin
        o_order_errs++;
        $display("o_valid seen with no pending instruction at cycle %0d", cyc);
      end
    end
    o_pending = exp_due.size();
  end

endmodule

/* bench/tb_int_core.sv */
`timescale 1ns/1ps

module tb_int_core import rv_core_pkg::*;;

  localparam int DW = XLEN;
  localparam int NR = NUM_REGS;

  logic                  clk;
  logic                  rst;
  logic                  valid;
  logic [31:0]           instr;
  logic                  out_valid;
  logic                  out_illegal;
  logic [$clog2(NR)-1:0] out_rd;
  logic [DW-1:0]         out_result;
  int                    value_errs;
  int                    order_errs;
  int                    pending;
  logic [31:0]           lfsr;

  int_core #(.DATA_WIDTH(DW), .N_REGS(NR)) i_int_core (
    .i_clk(clk), .i_rst(rst), .i_valid(valid), .i_instr(instr),
    .o_valid(out_valid), .o_illegal(out_illegal), .o_rd(out_rd), .o_result(out_result)
  );

  result_checker #(.DATA_WIDTH(DW), .N_REGS(NR)) u_checker (
    .i_clk(clk), .i_rst(rst), .i_valid(valid), .i_instr(instr),
    .i_dut_valid(out_valid), .i_dut_illegal(out_illegal), .i_dut_rd(out_rd),
    .i_dut_result(out_result), .o_value_errs(value_errs), .o_order_errs(order_errs),
    .o_pending(pending)
  );

  always #50 clk = ~clk;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic issue(input logic [31:0] word);
    valid = 1'b1;
    instr = word;
    @(negedge clk);
    valid = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  initial begin
    logic [1:0]  cls;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [31:0] word;
    int          gap;
    int          tmo;
    clk   = 1'b0;
    rst   = 1'b1;
    valid = 1'b0;
    instr = '0;
    lfsr  = 32'h38a6;
    idle(10);
    rst = 1'b0;
    // Prologue loads x1..x7, the first ones read unwritten sources
    for (int r = 1; r < 8; r++) begin
      imm = take_bits(12);
      rs1 = take_bits(3);
      issue({imm, rs1, 3'd0, 5'(r), OPC_OP_IMM});
    end
    for (int n = 0; n < 300; n++) begin
      cls = take_bits(2);
      f3  = take_bits(3);
      rd  = take_bits(3);  // Small range keeps dependencies dense
      rs1 = take_bits(3);
      rs2 = take_bits(3);
      case (cls)
        2'd0, 2'd1: begin
          f7 = ((f3 == 3'd0 || f3 == 3'd5) && take_bits(1)) ? 7'h20 : 7'h00;
          word = {f7, rs2, rs1, f3, rd, OPC_OP};
        end
        2'd2: begin
          imm = take_bits(12);
          if (f3 == 3'd1) imm[11:5] = 7'h00;
          if (f3 == 3'd5) imm[11:5] = take_bits(1) ? 7'h20 : 7'h00;
          word = {imm, rs1, f3, rd, OPC_OP_IMM};
        end
        default: begin
          word = take_bits(32);  // Mostly illegal
          if (take_bits(1)) word[6:0] = OPC_OP;
        end
      endcase
      issue(word);
      gap = take_bits(2);
      if (gap == 3) gap = 0;
      idle(gap);
    end
    tmo = 0;
    while ((pending != 0) && (tmo < 20)) begin
      @(posedge clk);
      tmo++;
    end
    if (pending != 0) begin
      $display("Timeout waiting for %0d instructions to retire", pending);
      $display("CHECKS FAILED");
    end else begin
      idle(3);
      $display("Closing: %0d value errors, %0d protocol errors", value_errs, order_errs);
      if ((value_errs == 0) && (order_errs == 0)) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
    end
    $finish;
  end

endmodule

/* design/alu_execute.sv */
`timescale 1ns/1ps

module alu_execute import rv_core_pkg::*; #(
  parameter int DATA_WIDTH = XLEN,
  parameter int N_REGS     = NUM_REGS
) (
  input  logic                      i_valid,
  input  logic                      i_illegal,
  input  logic [$clog2(N_REGS)-1:0] i_rd,
  input  logic [$clog2(N_REGS)-1:0] i_rs1,
  input  logic [$clog2(N_REGS)-1:0] i_rs2,
  input  alu_op_e                   i_alu_op,
  input  logic                      i_use_imm,
  input  logic [DATA_WIDTH-1:0]     i_imm,
  input  logic [DATA_WIDTH-1:0]     i_rdata1,
  input  logic [DATA_WIDTH-1:0]     i_rdata2,
  input  logic                      i_fwd_valid,
  input  logic [$clog2(N_REGS)-1:0] i_fwd_rd,
  input  logic [DATA_WIDTH-1:0]     i_fwd_result,
  output logic                      o_valid,
  output logic                      o_illegal,
  output logic [$clog2(N_REGS)-1:0] o_rd,
  output logic [DATA_WIDTH-1:0]     o_result
);

  localparam int SW = $clog2(DATA_WIDTH);

  logic                  fwd1;
  logic                  fwd2;
  logic [DATA_WIDTH-1:0] op1;
  logic [DATA_WIDTH-1:0] src2;
  logic [DATA_WIDTH-1:0] op2;
  logic [SW-1:0]         shamt;
  logic [DATA_WIDTH-1:0] alu_result;

  // Bypass from the instruction one stage ahead
  assign fwd1 = i_fwd_valid && (i_fwd_rd != '0) && (i_fwd_rd == i_rs1);
  assign fwd2 = i_fwd_valid && (i_fwd_rd != '0) && (i_fwd_rd == i_rs2);

  assign op1   = fwd1 ? i_fwd_result : i_rdata1;
  assign src2  = fwd2 ? i_fwd_result : i_rdata2;
  assign op2   = i_use_imm ? i_imm : src2;
  assign shamt = op2[SW-1:0];

  always_comb begin
    case (i_alu_op)
      ALU_ADD:  alu_result = op1 + op2;
      ALU_SUB:  alu_result = op1 - op2;
      ALU_SLL:  alu_result = op1 << shamt;
      ALU_SLT:  alu_result = DATA_WIDTH'($signed(op1) < $signed(op2));
      ALU_SLTU: alu_result = DATA_WIDTH'(op1 < op2);
      ALU_XOR:  alu_result = op1 ^ op2;
      ALU_SRL:  alu_result = op1 >> shamt;
      ALU_SRA:  alu_result = $signed(op1) >>> shamt;  // Sign fill
      ALU_OR:   alu_result = op1 | op2;
      ALU_AND:  alu_result = op1 & op2;
      default:  alu_result = '0;
    endcase
  end

  assign o_valid   = i_valid;
  assign o_illegal = i_illegal;
  assign o_rd      = i_rd;
  assign o_result  = i_illegal ? '0 : alu_result;  // Illegal words report zero

endmodule

/* design/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode import rv_core_pkg::*; #(
  parameter int DATA_WIDTH = XLEN,
  parameter int N_REGS     = NUM_REGS
) (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_valid,
  input  logic [31:0]               i_instr,
  output logic                      o_valid,
  output logic                      o_illegal,
  output logic [$clog2(N_REGS)-1:0] o_rd,
  output logic [$clog2(N_REGS)-1:0] o_rs1,
  output logic [$clog2(N_REGS)-1:0] o_rs2,
  output alu_op_e                   o_alu_op,
  output logic                      o_use_imm,
  output logic [DATA_WIDTH-1:0]     o_imm
);

  localparam int RW = $clog2(N_REGS);

  instr_u                iw;
  alu_op_e               alu_op;
  logic                  illegal;
  logic                  use_imm;
  logic [DATA_WIDTH-1:0] imm;
  logic [4:0]            rd;
  logic [4:0]            rs1;
  logic [4:0]            rs2;

  assign iw = i_instr;

  function automatic alu_op_e map_op(input logic [2:0] f3, input logic alt);
    case (f3)
      F3_ADD_SUB: map_op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     map_op = ALU_SLL;
      F3_SLT:     map_op = ALU_SLT;
      F3_SLTU:    map_op = ALU_SLTU;
      F3_XOR:     map_op = ALU_XOR;
      F3_SRL_SRA: map_op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      map_op = ALU_OR;
      F3_AND:     map_op = ALU_AND;
    endcase
  endfunction

  always_comb begin
    illegal = 1'b0;
    use_imm = 1'b0;
    imm     = {{(DATA_WIDTH-12){iw.i.imm[11]}}, iw.i.imm};
    rd      = iw.r.rd;
    rs1     = iw.r.rs1;
    rs2     = iw.r.rs2;
    alu_op  = map_op(iw.r.funct3, iw.r.funct7 == F7_ALT);
    case (iw.r.opcode)
      OPC_OP: begin
        if (iw.r.funct7 == F7_ALT) begin
          illegal = (iw.r.funct3 != F3_ADD_SUB) && (iw.r.funct3 != F3_SRL_SRA);
        end else begin
          illegal = (iw.r.funct7 != F7_BASE);
        end
        illegal = illegal || (rs2 >= N_REGS);
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        rd      = iw.i.rd;
        rs1     = iw.i.rs1;
        rs2     = '0;
        alu_op  = map_op(iw.i.funct3, 1'b0);
        if (iw.i.funct3 == F3_SLL) begin
          illegal = (iw.i.imm[11:5] != F7_BASE);
          imm     = DATA_WIDTH'(iw.i.imm[4:0]);  // shamt
        end else if (iw.i.funct3 == F3_SRL_SRA) begin
          illegal = (iw.i.imm[11:5] != F7_BASE) && (iw.i.imm[11:5] != F7_ALT);
          alu_op  = map_op(iw.i.funct3, iw.i.imm[11:5] == F7_ALT);
          imm     = DATA_WIDTH'(iw.i.imm[4:0]);
        end
      end
      default: illegal = 1'b1;
    endcase
    if ((rd >= N_REGS) || (rs1 >= N_REGS)) begin
      illegal = 1'b1;
    end
    // Nothing downstream may touch a register
    if (illegal) begin
      rd  = '0;
      rs1 = '0;
      rs2 = '0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid   <= 1'b0;
      o_illegal <= 1'b0;
    end else begin
      o_valid   <= i_valid;
      o_illegal <= i_valid && illegal;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_rd      <= rd[RW-1:0];
      o_rs1     <= rs1[RW-1:0];
      o_rs2     <= rs2[RW-1:0];
      o_alu_op  <= alu_op;
      o_use_imm <= use_imm;
      o_imm     <= imm;
    end
  end

endmodule

/* design/int_core.sv */
`timescale 1ns/1ps

module int_core import rv_core_pkg::*; #(
  parameter int DATA_WIDTH = XLEN,
  parameter int N_REGS     = NUM_REGS
) (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_valid,
  input  logic [31:0]               i_instr,
  output logic                      o_valid,
  output logic                      o_illegal,
  output logic [$clog2(N_REGS)-1:0] o_rd,
  output logic [DATA_WIDTH-1:0]     o_result
);

  localparam int RW = $clog2(N_REGS);

  logic                  d_valid;
  logic                  d_illegal;
  logic [RW-1:0]         d_rd;
  logic [RW-1:0]         d_rs1;
  logic [RW-1:0]         d_rs2;
  alu_op_e               d_alu_op;
  logic                  d_use_imm;
  logic [DATA_WIDTH-1:0] d_imm;
  logic [DATA_WIDTH-1:0] rf_rdata1;
  logic [DATA_WIDTH-1:0] rf_rdata2;
  logic                  x_valid;
  logic                  x_illegal;
  logic [RW-1:0]         x_rd;
  logic [DATA_WIDTH-1:0] x_result;
  logic                  r_we;

  instr_decode #(.DATA_WIDTH(DATA_WIDTH), .N_REGS(N_REGS)) u_decode (
    .i_clk(i_clk), .i_rst(i_rst), .i_valid(i_valid), .i_instr(i_instr),
    .o_valid(d_valid), .o_illegal(d_illegal), .o_rd(d_rd), .o_rs1(d_rs1),
    .o_rs2(d_rs2), .o_alu_op(d_alu_op), .o_use_imm(d_use_imm), .o_imm(d_imm)
  );

  register_file #(.DATA_WIDTH(DATA_WIDTH), .N_REGS(N_REGS)) u_regfile (
    .i_clk(i_clk), .i_rst(i_rst), .i_we(r_we), .i_waddr(o_rd), .i_wdata(o_result),
    .i_raddr1(d_rs1), .i_raddr2(d_rs2), .o_rdata1(rf_rdata1), .o_rdata2(rf_rdata2)
  );

  alu_execute #(.DATA_WIDTH(DATA_WIDTH), .N_REGS(N_REGS)) u_execute (
    .i_valid(d_valid), .i_illegal(d_illegal), .i_rd(d_rd), .i_rs1(d_rs1),
    .i_rs2(d_rs2), .i_alu_op(d_alu_op), .i_use_imm(d_use_imm), .i_imm(d_imm),
    .i_rdata1(rf_rdata1), .i_rdata2(rf_rdata2),
    .i_fwd_valid(r_we), .i_fwd_rd(o_rd), .i_fwd_result(o_result),  // Bypass
    .o_valid(x_valid), .o_illegal(x_illegal), .o_rd(x_rd), .o_result(x_result)
  );

  result_stage #(.DATA_WIDTH(DATA_WIDTH), .N_REGS(N_REGS)) u_result (
    .i_clk(i_clk), .i_rst(i_rst), .i_valid(x_valid), .i_illegal(x_illegal),
    .i_rd(x_rd), .i_result(x_result), .o_valid(o_valid), .o_illegal(o_illegal),
    .o_rd(o_rd), .o_result(o_result), .o_we(r_we)
  );

endmodule

/* design/register_file.sv */
`timescale 1ns/1ps

module register_file import rv_core_pkg::*; #(
  parameter int DATA_WIDTH = XLEN,
  parameter int N_REGS     = NUM_REGS
) (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_we,
  input  logic [$clog2(N_REGS)-1:0] i_waddr,
  input  logic [DATA_WIDTH-1:0]     i_wdata,
  input  logic [$clog2(N_REGS)-1:0] i_raddr1,
  input  logic [$clog2(N_REGS)-1:0] i_raddr2,
  output logic [DATA_WIDTH-1:0]     o_rdata1,
  output logic [DATA_WIDTH-1:0]     o_rdata2
);

  localparam int RW = $clog2(N_REGS);

  logic [DATA_WIDTH-1:0] regs  [1:N_REGS-1];
  logic [DATA_WIDTH-1:0] rview [0:N_REGS-1];
  logic [N_REGS-1:1]     we_vec;
  logic                  wr_en;

  // x0 never takes a write
  assign wr_en = i_we && (i_waddr != '0);

  // One-hot write enables
  always_comb begin
    for (int i = 1; i < N_REGS; i++) begin
      we_vec[i] = wr_en && (i_waddr == RW'(i));
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < N_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 1; i < N_REGS; i++) begin
        if (we_vec[i]) begin
          regs[i] <= i_wdata;
        end
      end
    end
  end

  // Read view with entry zero tied off
  always_comb begin
    rview[0] = '0;
    for (int i = 1; i < N_REGS; i++) begin
      rview[i] = regs[i];
    end
  end

  assign o_rdata1 = rview[i_raddr1];
  assign o_rdata2 = rview[i_raddr2];

endmodule

/* design/result_stage.sv */
`timescale 1ns/1ps

module result_stage import rv_core_pkg::*; #(
  parameter int DATA_WIDTH = XLEN,
  parameter int N_REGS     = NUM_REGS
) (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_valid,
  input  logic                      i_illegal,
  input  logic [$clog2(N_REGS)-1:0] i_rd,
  input  logic [DATA_WIDTH-1:0]     i_result,
  output logic                      o_valid,
  output logic                      o_illegal,
  output logic [$clog2(N_REGS)-1:0] o_rd,
  output logic [DATA_WIDTH-1:0]     o_result,
  output logic                      o_we
);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid   <= 1'b0;
      o_illegal <= 1'b0;
    end else begin
      o_valid   <= i_valid;
      o_illegal <= i_valid && i_illegal;
    end
  end

  always_ff @(posedge i_clk) begin
    o_rd     <= i_rd;
    o_result <= i_result;
  end

  // Write-back and bypass valid
  assign o_we = o_valid && !o_illegal;

endmodule

/* design/rv_core_pkg.sv */
package rv_core_pkg;

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB, SRA

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  // Same word, two decodings
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } instr_u;

endpackage
